// File: src/ice_pkg.sv
package ice_pkg;

	// Largest request the parser builds and the serializer sends
	localparam int max_bytes = 5;

	// One decoded hex digit
	typedef logic [3:0] nibble_t;

	// Command code, travels as the frame type bit
	typedef enum logic {
		cmd_write  = 1'b0,
		cmd_config = 1'b1
	} cmd_t;

	// Payload bytes in one request, 0 to max_bytes
	typedef logic [2:0] byte_count_t;

	// First byte on the wire sits in the top byte, unused low bytes are zero
	typedef logic [8*max_bytes-1:0] pint_data_t;

	// Characters the decoder recognizes beyond hex digits
	localparam logic [7:0] char_w  = 8'h77;
	localparam logic [7:0] char_c  = 8'h63;
	localparam logic [7:0] char_cr = 8'h0d;
	localparam logic [7:0] char_lf = 8'h0a;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
	parameter int clks_per_bit = 16
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);

	localparam int cnt_w = (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} state_t;

	state_t           state;
	logic             rx_meta;
	logic             rx_sync;
	logic             rx_prev;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_idx;
	logic [7:0]       shift_reg;
	logic             bit_end;
	logic             half_bit;

	assign bit_end  = clk_cnt == cnt_w'(clks_per_bit - 1);
	assign half_bit = clk_cnt == cnt_w'(clks_per_bit / 2 - 1);

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clk) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= st_idle;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			clk_cnt  <= clk_cnt + 1'b1;
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					if (rx_prev && !rx_sync) begin
						state <= st_start;
					end
				end
				st_start: begin
					// Recheck at mid start bit to reject glitches
					if (half_bit) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state   <= rx_sync ? st_idle : st_data;
					end
				end
				st_data: begin
					if (bit_end) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= st_stop;
						end
					end
				end
				st_stop: begin
					if (bit_end) begin
						rx_valid <= rx_sync;
						state    <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (state == st_data && bit_end) begin
			shift_reg <= {rx_sync, shift_reg[7:1]};
		end
		if (state == st_stop && bit_end) begin
			rx_data <= shift_reg;
		end
	end

	a_single_strobe: assert property (@(posedge clk) disable iff (reset)
		rx_valid |=> !rx_valid);

endmodule

// File: src/character_decoder.sv
`timescale 1ns/1ns

module character_decoder (
	input  logic             clk,
	input  logic             reset,
	input  logic [7:0]       rx_data,
	input  logic             rx_valid,
	output logic             char_valid,
	output logic             is_hex,
	output ice_pkg::nibble_t hex_value,
	output logic             is_cmd,
	output ice_pkg::cmd_t    cmd,
	output logic             is_eol
);
	import ice_pkg::*;

	logic    hex_hit;
	nibble_t hex_nib;
	logic    cmd_hit;
	cmd_t    cmd_code;
	logic    eol_hit;

	always_comb begin
		hex_hit  = 1'b0;
		hex_nib  = rx_data[3:0];
		cmd_hit  = 1'b0;
		cmd_code = cmd_write;
		eol_hit  = 1'b0;
		// Commands come first since lower-case c is also a hex letter
		if (rx_data == char_w) begin
			cmd_hit = 1'b1;
		end else if (rx_data == char_c) begin
			cmd_hit  = 1'b1;
			cmd_code = cmd_config;
		end else if (rx_data >= 8'h30 && rx_data <= 8'h39) begin
			hex_hit = 1'b1;
		end else if ((rx_data >= 8'h41 && rx_data <= 8'h46) ||
				(rx_data >= 8'h61 && rx_data <= 8'h66)) begin
			// Letters a to f have low nibble 1 to 6
			hex_hit = 1'b1;
			hex_nib = rx_data[3:0] + 4'd9;
		end else if (rx_data == char_cr || rx_data == char_lf) begin
			eol_hit = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			char_valid <= 1'b0;
			is_hex     <= 1'b0;
			is_cmd     <= 1'b0;
			is_eol     <= 1'b0;
		end else begin
			char_valid <= rx_valid;
			is_hex     <= rx_valid && hex_hit;
			is_cmd     <= rx_valid && cmd_hit;
			is_eol     <= rx_valid && eol_hit;
		end
	end

	always_ff @(posedge clk) begin
		if (rx_valid) begin
			hex_value <= hex_nib;
			cmd       <= cmd_code;
		end
	end

	a_one_class: assert property (@(posedge clk) disable iff (reset)
		$onehot0({is_hex, is_cmd, is_eol}) && (char_valid || !(is_hex || is_cmd || is_eol)));

endmodule

// File: src/command_parser.sv
`timescale 1ns/1ns

module command_parser (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 char_valid,
	input  logic                 is_hex,
	input  ice_pkg::nibble_t     hex_value,
	input  logic                 is_cmd,
	input  ice_pkg::cmd_t        cmd,
	input  logic                 is_eol,
	input  logic                 busy,
	output logic                 tx_req,
	output ice_pkg::cmd_t        tx_cmd,
	output ice_pkg::byte_count_t tx_num_bytes,
	output ice_pkg::pint_data_t  tx_data
);
	import ice_pkg::*;

	localparam int max_digits = 2 * max_bytes;
	localparam int data_w     = $bits(pint_data_t);

	typedef enum logic [1:0] {
		st_idle,
		st_collect,
		st_pending
	} state_t;

	state_t      state;
	cmd_t        line_cmd;
	pint_data_t  digits;
	logic [3:0]  digit_cnt;
	byte_count_t line_bytes;
	pint_data_t  keep_mask;
	logic        take_cmd;
	logic        take_digit;
	logic        take_eol;
	logic        launch;

	// Whole bytes only, an odd last digit falls away
	assign line_bytes = digit_cnt[3:1];
	assign keep_mask  = ~(pint_data_t'('1) >> (8 * line_bytes));

	// Nothing is taken while a request waits
	assign take_cmd   = char_valid && is_cmd && state != st_pending;
	assign take_digit = char_valid && is_hex && state == st_collect &&
		digit_cnt < 4'(max_digits);
	assign take_eol   = char_valid && is_eol && state == st_collect;
	assign launch     = take_eol && line_bytes != '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			line_cmd  <= cmd_write;
			digit_cnt <= '0;
			tx_req    <= 1'b0;
		end else begin
			case (state)
				st_idle, st_collect: begin
					if (take_cmd) begin
						state     <= st_collect;
						line_cmd  <= cmd;
						digit_cnt <= '0;
					end else if (take_digit) begin
						digit_cnt <= digit_cnt + 4'd1;
					end else if (take_eol) begin
						digit_cnt <= '0;
						if (launch) begin
							tx_req <= 1'b1;
							state  <= st_pending;
						end
					end
				end
				st_pending: begin
					// Accepted this cycle, line command stays in force
					if (!busy) begin
						tx_req <= 1'b0;
						state  <= st_collect;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Digits fill from the top so the first typed byte lands in the top byte
	always_ff @(posedge clk) begin
		if (take_cmd || take_eol) begin
			digits <= '0;
		end else if (take_digit) begin
			digits[data_w - 1 - 4 * digit_cnt -: 4] <= hex_value;
		end
		if (launch) begin
			tx_cmd       <= line_cmd;
			tx_num_bytes <= line_bytes;
			tx_data      <= digits & keep_mask;
		end
	end

	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		tx_req && busy |=> tx_req && $stable(tx_data) && $stable(tx_num_bytes) &&
			$stable(tx_cmd));

endmodule

// File: src/pint_serializer.sv
`timescale 1ns/1ns

module pint_serializer #(
	parameter int pint_half = 2
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 tx_req,
	input  ice_pkg::cmd_t        tx_cmd,
	input  ice_pkg::byte_count_t tx_num_bytes,
	input  ice_pkg::pint_data_t  tx_data,
	output logic                 busy,
	output logic                 pint_wrreq,
	output logic                 pint_wrdata,
	output logic                 pint_clk,
	output logic                 pint_resetn
);
	import ice_pkg::*;

	// Type bit, 3-bit count, then the payload bytes
	localparam int frame_bits = 4 + 8 * max_bytes;
	localparam int half_w     = (pint_half > 1) ? $clog2(pint_half) : 1;
	localparam int count_w    = $clog2(frame_bits + 1);

	logic                  active;
	logic [frame_bits-1:0] shift_reg;
	logic [count_w-1:0]    bits_left;
	logic [half_w-1:0]     half_cnt;
	logic                  half_done;
	logic                  accept;
	logic                  bit_done;

	assign accept    = tx_req && !active;
	assign half_done = half_cnt == half_w'(pint_half - 1);
	// Last cycle of a high phase
	assign bit_done  = active && half_done && pint_clk;

	always_ff @(posedge clk) begin
		if (reset) begin
			active    <= 1'b0;
			pint_clk  <= 1'b0;
			half_cnt  <= '0;
			bits_left <= '0;
		end else if (accept) begin
			active    <= 1'b1;
			pint_clk  <= 1'b0;
			half_cnt  <= '0;
			bits_left <= count_w'(4 + 8 * tx_num_bytes);
		end else if (active) begin
			if (half_done) begin
				half_cnt <= '0;
				pint_clk <= ~pint_clk;
				if (pint_clk) begin
					bits_left <= bits_left - 1'b1;
					if (bits_left == count_w'(1)) begin
						active <= 1'b0;
					end
				end
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// Payload is top aligned, so only the leading 4+8N bits go out
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= {tx_cmd, tx_num_bytes, tx_data};
		end else if (bit_done) begin
			shift_reg <= {shift_reg[frame_bits-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk) begin
		pint_resetn <= ~reset;
	end

	assign busy        = active;
	assign pint_wrreq  = active;
	assign pint_wrdata = active && shift_reg[frame_bits-1];

	a_clk_in_frame: assert property (@(posedge clk) disable iff (reset)
		pint_clk |-> pint_wrreq);

endmodule

// File: src/ice_controller.sv
`timescale 1ns/1ns

module ice_controller #(
	parameter int clks_per_bit = 16,
	parameter int pint_half    = 2
) (
	input  logic clk,
	input  logic reset,
	input  logic uart_rx_line,
	output logic pint_wrreq,
	output logic pint_wrdata,
	output logic pint_clk,
	output logic pint_resetn
);
	import ice_pkg::*;

	// UART receiver to decoder
	logic [7:0] rx_data;
	logic       rx_valid;

	// Decoder to parser
	logic       char_valid;
	logic       is_hex;
	nibble_t    hex_value;
	logic       is_cmd;
	cmd_t       cmd;
	logic       is_eol;

	// Parser to serializer
	logic        tx_req;
	cmd_t        tx_cmd;
	byte_count_t tx_num_bytes;
	pint_data_t  tx_data;
	logic        busy;

	uart_rx #(
		.clks_per_bit(clks_per_bit)
	) u_uart_rx (
		.clk     (clk),
		.reset   (reset),
		.rx      (uart_rx_line),
		.rx_data (rx_data),
		.rx_valid(rx_valid)
	);

	character_decoder u_decoder (
		.clk       (clk),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.char_valid(char_valid),
		.is_hex    (is_hex),
		.hex_value (hex_value),
		.is_cmd    (is_cmd),
		.cmd       (cmd),
		.is_eol    (is_eol)
	);

	command_parser u_parser (
		.clk         (clk),
		.reset       (reset),
		.char_valid  (char_valid),
		.is_hex      (is_hex),
		.hex_value   (hex_value),
		.is_cmd      (is_cmd),
		.cmd         (cmd),
		.is_eol      (is_eol),
		.busy        (busy),
		.tx_req      (tx_req),
		.tx_cmd      (tx_cmd),
		.tx_num_bytes(tx_num_bytes),
		.tx_data     (tx_data)
	);

	pint_serializer #(
		.pint_half(pint_half)
	) u_serializer (
		.clk         (clk),
		.reset       (reset),
		.tx_req      (tx_req),
		.tx_cmd      (tx_cmd),
		.tx_num_bytes(tx_num_bytes),
		.tx_data     (tx_data),
		.busy        (busy),
		.pint_wrreq  (pint_wrreq),
		.pint_wrdata (pint_wrdata),
		.pint_clk    (pint_clk),
		.pint_resetn (pint_resetn)
	);

endmodule

// File: dv/ice_controller_tb.sv
`timescale 1ns/1ns

module ice_controller_tb;
	import ice_pkg::*;

	localparam int clks_per_bit = 16;
	localparam int pint_half    = 2;
	localparam int frame_len    = 4 + 8 * max_bytes;
	localparam int frame_cycles = frame_len * 2 * pint_half;
	// Ten bits plus the longest random gap
	localparam int char_cycles  = 10 * clks_per_bit + 8;

	logic clk;
	logic reset;
	logic uart_line;
	logic pint_wrreq;
	logic pint_wrdata;
	logic pint_clk;
	logic pint_resetn;

	// Stimulus table with one entry per typed line
	byte         row_cmd[$];
	string       row_text[$];
	int          row_noise[$];
	cmd_t        row_type[$];
	byte_count_t row_count[$];
	pint_data_t  row_data[$];

	// Frames still owed by the DUT with the oldest first
	cmd_t        exp_type[$];
	byte_count_t exp_count[$];
	pint_data_t  exp_data[$];

	int    value_errors;
	int    missing_frames;
	int    extra_frames;
	int    seed;
	int    watch_cycles;
	string noise_set;

	ice_controller #(
		.clks_per_bit(clks_per_bit),
		.pint_half   (pint_half)
	) uut (
		.clk         (clk),
		.reset       (reset),
		.uart_rx_line(uart_line),
		.pint_wrreq  (pint_wrreq),
		.pint_wrdata (pint_wrdata),
		.pint_clk    (pint_clk),
		.pint_resetn (pint_resetn)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic add_row(input byte cmd_char, input string text, input int noise,
			input cmd_t typ, input byte_count_t count, input pint_data_t data);
		row_cmd.push_back(cmd_char);
		row_text.push_back(text);
		row_noise.push_back(noise);
		row_type.push_back(typ);
		row_count.push_back(count);
		row_data.push_back(data);
	endtask

	// A zero count marks a line that gives no frame
	task automatic build_table();
		add_row("w", "a5", 0, cmd_write, 3'd1, 40'ha500000000);
		add_row("w", "1234", 0, cmd_write, 3'd2, 40'h1234000000);
		add_row("w", "0123456789", 0, cmd_write, 3'd5, 40'h0123456789);
		add_row("c", "beef", 0, cmd_config, 3'd2, 40'hbeef000000);
		add_row(8'h00, "42", 0, cmd_config, 3'd1, 40'h4200000000);
		add_row(8'h00, "12345", 0, cmd_config, 3'd2, 40'h1234000000);
		add_row(8'h00, "", 0, cmd_config, 3'd0, 40'h0);
		add_row(8'h00, "7", 0, cmd_config, 3'd0, 40'h0);
		add_row("w", "0123456789abef", 0, cmd_write, 3'd5, 40'h0123456789);
		add_row("w", "DEADBEEF", 0, cmd_write, 3'd4, 40'hdeadbeef00);
		add_row("w", "deadbeef", 4, cmd_write, 3'd4, 40'hdeadbeef00);
		add_row(8'h00, "12c3456", 0, cmd_config, 3'd2, 40'h3456000000);
		add_row(8'h00, "5a5A", 3, cmd_config, 3'd2, 40'h5a5a000000);
		add_row("w", "abe", 0, cmd_write, 3'd1, 40'hab00000000);
	endtask

	task automatic check_type(input cmd_t got, input cmd_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR frame_type got %h expected %h", got, exp);
		end
	endtask

	task automatic check_count(input byte_count_t got, input byte_count_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR frame_count got %h expected %h", got, exp);
		end
	endtask

	task automatic check_data(input pint_data_t got, input pint_data_t exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR frame_data got %h expected %h", got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			value_errors++;
			$display("ERR %s got %h expected %h", name, got, exp);
		end
	endtask

	// Start bit, eight data bits LSB first, stop bit
	task automatic send_byte(input logic [7:0] value);
		logic [9:0] bits;
		int         i;
		bits = {1'b1, value, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(negedge clk);
			uart_line = bits[i];
			repeat (clks_per_bit - 1) @(negedge clk);
		end
	endtask

	task automatic idle_gap();
		repeat ($unsigned($random(seed)) % 8) @(negedge clk);
	endtask

	task automatic send_noise();
		int idx;
		idx = $unsigned($random(seed)) % noise_set.len();
		send_byte(noise_set[idx]);
		idle_gap();
	endtask

	task automatic send_line(input byte cmd_char, input string text, input int noise);
		int left;
		int i;
		left = noise;
		if (cmd_char != 8'h00) begin
			send_byte(cmd_char);
			idle_gap();
		end
		for (i = 0; i < text.len(); i++) begin
			if (left > 0 && ($random(seed) & 1) != 0) begin
				send_noise();
				left--;
			end
			send_byte(text[i]);
			idle_gap();
		end
		while (left > 0) begin
			send_noise();
			left--;
		end
		send_byte(char_cr);
		idle_gap();
	endtask

	// Bits are listed in wire order starting at index 0
	task automatic check_frame(input logic [frame_len-1:0] bits, input int bit_cnt);
		cmd_t        got_type;
		byte_count_t got_count;
		pint_data_t  got_data;
		int          i;
		got_type  = cmd_t'(bits[0]);
		got_count = {bits[1], bits[2], bits[3]};
		got_data  = '0;
		for (i = 4; i < bit_cnt; i++) begin
			got_data[frame_len - 1 - i] = bits[i];
		end
		if (exp_type.size() == 0) begin
			extra_frames++;
			$display("Unexpected frame of %0d bits with no line waiting for it", bit_cnt);
		end else begin
			check_type(got_type, exp_type.pop_front());
			check_count(got_count, exp_count.pop_front());
			check_data(got_data, exp_data.pop_front());
			if (bit_cnt != 4 + 8 * int'(got_count)) begin
				value_errors++;
				$display("Frame of %0d bits does not match its count field", bit_cnt);
			end
		end
	endtask

	// Rising pint_clk is caught at the falling clk edge where the bus is settled
	initial begin : frame_monitor
		logic [frame_len-1:0] bits;
		int                   bit_cnt;
		logic                 clk_prev;
		logic                 req_prev;
		bits     = '0;
		bit_cnt  = 0;
		clk_prev = 1'b0;
		req_prev = 1'b0;
		forever begin
			@(negedge clk);
			if (pint_wrreq === 1'b1 && pint_clk === 1'b1 && clk_prev !== 1'b1 &&
					bit_cnt < frame_len) begin
				bits[bit_cnt] = pint_wrdata;
				bit_cnt++;
			end
			if (pint_wrreq !== 1'b1 && req_prev === 1'b1) begin
				check_frame(bits, bit_cnt);
				bits    = '0;
				bit_cnt = 0;
			end
			clk_prev = pint_clk;
			req_prev = pint_wrreq;
		end
	end

	initial begin : watchdog
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", watch_cycles);
		$display("** FAIL **");
		$finish;
	end

	initial begin : main_seq
		int r;
		int chars;
		int drain;
		reset          = 1'b1;
		uart_line      = 1'b1;
		value_errors   = 0;
		missing_frames = 0;
		extra_frames   = 0;
		seed           = 33791;
		watch_cycles   = 0;
		noise_set      = "ghijkz+-._";
		build_table();

		chars = 0;
		for (r = 0; r < row_cmd.size(); r++) begin
			chars += row_text[r].len() + row_noise[r] + 2;
		end
		watch_cycles = 2 * chars * char_cycles + row_cmd.size() * frame_cycles + 200;

		// Bus stays quiet and held in reset
		for (r = 0; r < 8; r++) begin
			@(negedge clk);
			if (r > 0) begin
				check_level("pint_resetn", pint_resetn, 1'b0);
				check_level("pint_wrreq", pint_wrreq, 1'b0);
				check_level("pint_clk", pint_clk, 1'b0);
			end
		end
		reset = 1'b0;
		repeat (2) @(negedge clk);
		check_level("pint_resetn", pint_resetn, 1'b1);
		repeat (4 * clks_per_bit) @(negedge clk);

		for (r = 0; r < row_cmd.size(); r++) begin
			if (row_count[r] != '0) begin
				exp_type.push_back(row_type[r]);
				exp_count.push_back(row_count[r]);
				exp_data.push_back(row_data[r]);
			end
			send_line(row_cmd[r], row_text[r], row_noise[r]);
		end

		// Let the last frame drain out
		drain = 0;
		while ((exp_type.size() != 0 || pint_wrreq !== 1'b0) &&
				drain < 2 * frame_cycles + char_cycles) begin
			@(negedge clk);
			drain++;
		end
		repeat (4) @(negedge clk);
		while (exp_type.size() != 0) begin
			missing_frames++;
			$display("Missing frame: a line with %0d bytes produced no frame",
				exp_count.pop_front());
			void'(exp_type.pop_front());
			void'(exp_data.pop_front());
		end

		$display("Errors: %0d value, %0d missing frame, %0d extra frame",
			value_errors, missing_frames, extra_frames);
		if (value_errors == 0 && missing_frames == 0 && extra_frames == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: ice_ctrl.f
src/ice_pkg.sv
src/uart_rx.sv
src/character_decoder.sv
src/command_parser.sv
src/pint_serializer.sv
src/ice_controller.sv
dv/ice_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ice_controller_tb \
	-f ice_ctrl.f -o ice_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ice_sim > sim.log 2>&1
grep -qx '\*\* PASS \*\*' sim.log \
	&& echo "simulation passed, see sim.log" \
	|| { cat sim.log; echo "simulation failed"; exit 1; }
